// ==== run_sim.sh ====
#!/bin/sh
# Build and run the kernel testbench with Verilator, then scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f verilog.f --top-module tb_add_fork_kernel \
  -Mdir obj_dir -o tb_sim \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "STATUS: FAIL" sim.log && exit 1 || exit 0

// ==== verif/tb_add_fork_kernel.sv ====
// Inputs change 1 unit after each rising edge and outputs are sampled on falling edges
`default_nettype none

`include "df_params.svh"

module tb_add_fork_kernel;

  localparam int SEED             = 92;
  localparam int NUM_RANDOM_PAIRS = 300;
  localparam int PAIR_TIMEOUT     = 200;
  localparam int WAIT_TIMEOUT     = 50;
  localparam int DRAIN_TIMEOUT    = 2000;

  // Ready patterns for the fork outputs
  localparam int MODE_ALL    = 0;
  localparam int MODE_STALL  = 1;
  localparam int MODE_RANDOM = 2;

  logic                         clk;
  logic                         rst;
  df_data_pkg::data_t           a;
  df_data_pkg::data_t           b;
  logic                         a_valid;
  logic                         b_valid;
  logic                         a_ready;
  logic                         b_ready;
  df_data_pkg::data_t           outs;
  df_handshake_pkg::fork_mask_t outs_valid;
  df_handshake_pkg::fork_mask_t outs_ready;

  // One expected-sum queue per fork output
  df_data_pkg::data_t exp_q [`DF_FORK_OUTS][$];
  int                 delivered [`DF_FORK_OUTS];
  int                 mismatch_count = 0;
  int                 timeout_count = 0;
  int                 other_count = 0;
  int                 cycle_count = 0;
  int                 ready_mode = MODE_ALL;
  logic [15:0]        lfsr_state = 16'(SEED);

  tb_clock_gen #(.PERIOD(4)) clock_src (.clk(clk));

  add_fork_kernel uut (
    .clk        (clk),
    .rst        (rst),
    .a          (a),
    .b          (b),
    .a_valid    (a_valid),
    .b_valid    (b_valid),
    .a_ready    (a_ready),
    .b_ready    (b_ready),
    .outs       (outs),
    .outs_valid (outs_valid),
    .outs_ready (outs_ready)
  );

  always @(posedge clk) cycle_count <= cycle_count + 1;

  // 16-bit Fibonacci LFSR with taps 16 14 13 11
  // One step per returned bit
  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  // Carry out of the top bit is dropped
  function automatic df_data_pkg::data_t ref_sum(input df_data_pkg::data_t x,
                                                 input df_data_pkg::data_t y);
    logic [`DF_DATA_WIDTH:0] full;
    full = {1'b0, x} + {1'b0, y};
    return full[`DF_DATA_WIDTH-1:0];
  endfunction

  function automatic int pending_total();
    int n;
    n = 0;
    for (int i = 0; i < `DF_FORK_OUTS; i++) n += exp_q[i].size();
    return n;
  endfunction

  task automatic compare_word(input string name, input df_data_pkg::data_t expected,
                              input df_data_pkg::data_t actual);
    if (actual !== expected) begin
      mismatch_count++;
      $display("MISMATCH time=%0t signal=%s expected=%h actual=%h", $time, name, expected, actual);
    end
  endtask

  task automatic verify_mask(input string name, input df_handshake_pkg::fork_mask_t expected,
                             input df_handshake_pkg::fork_mask_t actual);
    if (actual !== expected) begin
      mismatch_count++;
      $display("MISMATCH time=%0t signal=%s expected=%b actual=%b", $time, name, expected, actual);
    end
  endtask

  // Advance to the next rising edge and drive new output readies
  task automatic step_cycle();
    @(posedge clk);
    #1;
    case (ready_mode)
      MODE_ALL:   outs_ready = '1;
      MODE_STALL: outs_ready = df_handshake_pkg::fork_mask_t'(1);
      default:    outs_ready = df_handshake_pkg::fork_mask_t'(lfsr_bits(`DF_FORK_OUTS));
    endcase
  endtask

  // Valids rise after their own gaps and stay up until the pair is taken
  task automatic drive_pair(input df_data_pkg::data_t x, input df_data_pkg::data_t y,
                            input bit gaps);
    int gap_a;
    int gap_b;
    int waited;
    bit taken;
    gap_a = gaps ? int'(lfsr_bits(2)) : 0;
    gap_b = gaps ? int'(lfsr_bits(2)) : 0;
    a = x;
    b = y;
    waited = 0;
    taken = 1'b0;
    while (!taken && waited < PAIR_TIMEOUT) begin
      a_valid = (waited >= gap_a);
      b_valid = (waited >= gap_b);
      @(negedge clk);
      taken = a_valid && a_ready && b_valid && b_ready;
      step_cycle();
      waited++;
    end
    if (!taken) begin
      timeout_count++;
      $display("Timeout: operand pair %h and %h was never taken", x, y);
    end
  endtask

  task automatic random_pair(input bit gaps);
    df_data_pkg::data_t x;
    df_data_pkg::data_t y;
    x = df_data_pkg::data_t'(lfsr_bits(`DF_DATA_WIDTH));
    y = df_data_pkg::data_t'(lfsr_bits(`DF_DATA_WIDTH));
    drive_pair(x, y, gaps);
  endtask

  task automatic wait_drained(input string phase);
    int waited;
    waited = 0;
    while (pending_total() != 0 && waited < DRAIN_TIMEOUT) begin
      step_cycle();
      waited++;
    end
    if (pending_total() != 0) begin
      timeout_count++;
      $display("Timeout: %0d expected sums still pending after %s", pending_total(), phase);
    end
  endtask

  // Monitor samples at the falling edge where every signal is stable
  always @(negedge clk) begin
    df_data_pkg::data_t expected;
    if (rst) begin
      verify_mask("outs_valid", '0, outs_valid);
    end else begin
      if (a_valid && a_ready && b_valid && b_ready) begin
        for (int i = 0; i < `DF_FORK_OUTS; i++) exp_q[i].push_back(ref_sum(a, b));
      end
      // Operands leave as a pair or not at all
      if ((a_valid && a_ready) != (b_valid && b_ready)) begin
        other_count++;
        $display("Only one operand was consumed at time %0t", $time);
      end
      for (int i = 0; i < `DF_FORK_OUTS; i++) begin
        if (outs_valid[i] && outs_ready[i]) begin
          delivered[i]++;
          if (exp_q[i].size() == 0) begin
            other_count++;
            $display("Output %0d delivered %h at time %0t with no sum pending", i, outs, $time);
          end else begin
            expected = exp_q[i].pop_front();
            compare_word($sformatf("outs[%0d]", i), expected, outs);
          end
        end
      end
    end
  end

  initial begin
    int start_cycle;
    int waited;
    int served_before [`DF_FORK_OUTS];
    rst = 1'b1;
    a = '0;
    b = '0;
    a_valid = 1'b0;
    b_valid = 1'b0;
    outs_ready = '1;
    for (int i = 0; i < `DF_FORK_OUTS; i++) delivered[i] = 0;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    verify_mask("outs_valid", '0, outs_valid);
    step_cycle();

    // Latency of a lone pair counted edge to edge
    drive_pair(32'h0000_0011, 32'h0000_0022, 1'b0);
    a_valid = 1'b0;
    b_valid = 1'b0;
    start_cycle = cycle_count;
    waited = 0;
    while (outs_valid == '0 && waited < WAIT_TIMEOUT) begin
      step_cycle();
      waited++;
    end
    if (outs_valid == '0) begin
      timeout_count++;
      $display("Timeout: first sum never reached the outputs");
    end else if (cycle_count + 1 - start_cycle != `DF_NUM_SLOTS) begin
      mismatch_count++;
      $display("MISMATCH time=%0t signal=latency expected=%0d actual=%0d",
               $time, `DF_NUM_SLOTS, cycle_count + 1 - start_cycle);
    end
    verify_mask("outs_valid", '1, outs_valid);
    wait_drained("latency check");

    // Back-to-back pairs with one wrapping sum
    drive_pair(32'hFFFF_FFFF, 32'h0000_0002, 1'b0);
    for (int k = 0; k < 20; k++) random_pair(1'b0);
    a_valid = 1'b0;
    b_valid = 1'b0;
    wait_drained("back-to-back pairs");

    // Only a valid while b stays low
    a = 32'h1234_5678;
    b = 32'h0101_0101;
    a_valid = 1'b1;
    b_valid = 1'b0;
    for (int c = 0; c < 6; c++) step_cycle();
    verify_mask("outs_valid", '0, outs_valid);
    drive_pair(32'h1234_5678, 32'h0101_0101, 1'b0);
    a_valid = 1'b0;
    b_valid = 1'b0;
    wait_drained("single operand");

    // Output 0 ready while the rest are stalled
    for (int i = 0; i < `DF_FORK_OUTS; i++) served_before[i] = delivered[i];
    ready_mode = MODE_STALL;
    outs_ready = df_handshake_pkg::fork_mask_t'(1);
    random_pair(1'b0);
    random_pair(1'b0);
    a_valid = 1'b0;
    b_valid = 1'b0;
    for (int c = 0; c < 8; c++) step_cycle();
    verify_mask("outs_valid", ~df_handshake_pkg::fork_mask_t'(1), outs_valid);
    if (delivered[0] - served_before[0] != 1) begin
      mismatch_count++;
      $display("MISMATCH time=%0t signal=delivered[0] expected=1 actual=%0d",
               $time, delivered[0] - served_before[0]);
    end
    ready_mode = MODE_ALL;
    wait_drained("stalled output");

    // Random valid gaps and random readies
    ready_mode = MODE_RANDOM;
    for (int k = 0; k < NUM_RANDOM_PAIRS; k++) random_pair(1'b1);
    a_valid = 1'b0;
    b_valid = 1'b0;
    ready_mode = MODE_ALL;
    wait_drained("random traffic");

    for (int i = 0; i < `DF_FORK_OUTS; i++) begin
      if (exp_q[i].size() != 0) begin
        other_count++;
        $display("Output %0d ended with %0d sums never delivered", i, exp_q[i].size());
      end
    end

    $display("Errors: mismatches=%0d timeouts=%0d other=%0d",
             mismatch_count, timeout_count, other_count);
    if (mismatch_count + timeout_count + other_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verif/tb_clock_gen.sv ====
// Free-running testbench clock; starts low at time 0, PERIOD must be even
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD = 4
) (
  output logic clk
);

  // Half period per level
  localparam int HALF = PERIOD / 2;

  initial begin
    clk = 1'b0;
    forever #HALF clk = ~clk;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+verilog
verilog/df_data_pkg.sv
verilog/df_handshake_pkg.sv
verilog/shift_reg_break_dv_dataless.sv
verilog/shift_reg_break_dv.sv
verilog/addi.sv
verilog/fork_eager.sv
verilog/add_fork_kernel.sv
verif/tb_clock_gen.sv
verif/tb_add_fork_kernel.sv

// ==== verilog/add_fork_kernel.sv ====
// Adder, buffer and fork in series; zero-stall latency is DF_NUM_SLOTS cycles from pair to outputs
`default_nettype none

`include "df_params.svh"

module add_fork_kernel (
  input  wire logic                         clk,
  input  wire logic                         rst,
  input  wire df_data_pkg::data_t           a,
  input  wire df_data_pkg::data_t           b,
  input  wire logic                         a_valid,
  input  wire logic                         b_valid,
  output logic                              a_ready,
  output logic                              b_ready,
  output df_data_pkg::data_t                outs,
  output df_handshake_pkg::fork_mask_t      outs_valid,
  input  wire df_handshake_pkg::fork_mask_t outs_ready
);

  // Adder to buffer
  df_data_pkg::data_t sum;
  logic               sum_valid;
  logic               sum_ready;

  // Buffer to fork
  df_data_pkg::data_t buf_data;
  logic               buf_valid;
  logic               buf_ready;

  addi u_addi (
    .a         (a),
    .b         (b),
    .a_valid   (a_valid),
    .b_valid   (b_valid),
    .a_ready   (a_ready),
    .b_ready   (b_ready),
    .sum       (sum),
    .sum_valid (sum_valid),
    .sum_ready (sum_ready)
  );

  // Breaks the data and valid path after the adder
  shift_reg_break_dv #(
    .NUM_SLOTS (`DF_NUM_SLOTS),
    .data_t    (df_data_pkg::data_t)
  ) u_buf (
    .clk        (clk),
    .rst        (rst),
    .ins        (sum),
    .ins_valid  (sum_valid),
    .ins_ready  (sum_ready),
    .outs       (buf_data),
    .outs_valid (buf_valid),
    .outs_ready (buf_ready)
  );

  fork_eager u_fork (
    .clk        (clk),
    .rst        (rst),
    .ins        (buf_data),
    .ins_valid  (buf_valid),
    .ins_ready  (buf_ready),
    .outs       (outs),
    .outs_valid (outs_valid),
    .outs_ready (outs_ready)
  );

endmodule

`default_nettype wire

// ==== verilog/addi.sv ====
// Combinational join-and-add; operands are taken only as a pair, and the sum wraps silently
`default_nettype none

module addi (
  input  wire df_data_pkg::data_t a,
  input  wire df_data_pkg::data_t b,
  input  wire logic               a_valid,
  input  wire logic               b_valid,
  output logic                    a_ready,
  output logic                    b_ready,
  output df_data_pkg::data_t      sum,
  output logic                    sum_valid,
  input  wire logic               sum_ready
);

  // Join of the two operand channels
  always_comb begin
    sum_valid = a_valid & b_valid;
    // Both operands leave in the same cycle as the sum
    a_ready = sum_valid & sum_ready;
    b_ready = sum_valid & sum_ready;
  end

  // Modulo 2^32, carry dropped
  assign sum = a + b;

  // A lone operand is never consumed
  always_comb begin
    a_pair_ready: assert (a_ready == b_ready)
      else $error("addi: a_ready and b_ready differ");
  end

endmodule

`default_nettype wire

// ==== verilog/df_data_pkg.sv ====
// Datapath word type only; its width comes from DF_DATA_WIDTH in df_params.svh
`default_nettype none

`include "df_params.svh"

package df_data_pkg;

  // One kernel word
  // Operands, sums and fork outputs all use it
  // No carry bit, so arithmetic wraps
  typedef logic [`DF_DATA_WIDTH-1:0] data_t;

endpackage

`default_nettype wire

// ==== verilog/df_handshake_pkg.sv ====
// Handshake vector types for the fork; bit i always refers to fork output i
`default_nettype none

`include "df_params.svh"

package df_handshake_pkg;

  // One bit per fork output
  // Used for outs_valid, outs_ready and the served flags
  // Bit 0 is the first output channel
  typedef logic [`DF_FORK_OUTS-1:0] fork_mask_t;

endpackage

`default_nettype wire

// ==== verilog/df_params.svh ====
// Kernel-wide sizes; the buffer needs at least 1 slot and the fork at least 1 output
`ifndef DF_PARAMS_SVH
`define DF_PARAMS_SVH

// Width of one kernel word in bits
// Sums wrap modulo 2^DF_DATA_WIDTH
`define DF_DATA_WIDTH 32

// Depth of the shift-register buffer
// Also the zero-stall latency of the kernel, in cycles
`define DF_NUM_SLOTS 2

// Number of eager fork outputs
// One served flag per output
`define DF_FORK_OUTS 2

`endif

// ==== verilog/fork_eager.sv ====
// Eager fork; each output takes a token once, the input waits until every output has it
`default_nettype none

module fork_eager (
  input  wire logic                     clk,
  input  wire logic                     rst,
  input  wire df_data_pkg::data_t       ins,
  input  wire logic                     ins_valid,
  output logic                          ins_ready,
  output df_data_pkg::data_t            outs,
  output df_handshake_pkg::fork_mask_t  outs_valid,
  input  wire df_handshake_pkg::fork_mask_t outs_ready
);

  // Set once an output has taken the current token
  df_handshake_pkg::fork_mask_t served;
  df_handshake_pkg::fork_mask_t done;
  df_handshake_pkg::fork_mask_t taken;
  logic                         ins_fire;

  // Same word on every output
  assign outs = ins;

  // Offer only to outputs that still lack the token
  assign outs_valid = {$bits(outs_valid){ins_valid}} & ~served;

  // Transfers happening this cycle, per output
  assign taken = outs_valid & outs_ready;

  // An output is finished if already served or taking it now
  assign done      = served | outs_ready;
  assign ins_ready = &done;
  assign ins_fire  = ins_valid & ins_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      served <= '0;
    end else if (ins_fire) begin
      // Token gone, next one starts unserved everywhere
      served <= '0;
    end else begin
      // Partial delivery, remember who got it
      served <= served | taken;
    end
  end

  // Served outputs never see the token twice
  a_no_repeat: assert property (
    @(posedge clk) disable iff (rst)
    (outs_valid & served) == '0
  ) else $error("fork_eager: output valid while already served");

endmodule

`default_nettype wire

// ==== verilog/shift_reg_break_dv.sv ====
// Data/valid breaking buffer of NUM_SLOTS stages; payload slots hold X until the first tokens
`default_nettype none

`include "df_params.svh"

module shift_reg_break_dv #(
  parameter int  NUM_SLOTS = `DF_NUM_SLOTS,
  parameter type data_t    = logic [`DF_DATA_WIDTH-1:0]
) (
  input  wire logic clk,
  input  wire logic rst,
  input  wire data_t ins,
  input  wire logic  ins_valid,
  output logic       ins_ready,
  output data_t      outs,
  output logic       outs_valid,
  input  wire logic  outs_ready
);

  // Payload slots, index 0 at the input
  data_t mem [NUM_SLOTS];
  logic  reg_en;

  // Handshake control lives in the dataless core
  shift_reg_break_dv_dataless #(
    .NUM_SLOTS (NUM_SLOTS)
  ) control (
    .clk        (clk),
    .rst        (rst),
    .ins_valid  (ins_valid),
    .outs_ready (outs_ready),
    .outs_valid (outs_valid),
    .ins_ready  (reg_en)
  );

  // Same enable as the valid bits
  // Payload and valid stay aligned slot for slot
  always_ff @(posedge clk) begin
    if (reg_en) begin
      for (int i = NUM_SLOTS - 1; i > 0; i--) begin
        mem[i] <= mem[i-1];
      end
      mem[0] <= ins;
    end
  end

  assign outs      = mem[NUM_SLOTS-1];
  assign ins_ready = reg_en;

  // Consumer sees the same word until it takes it
  a_data_stable: assert property (
    @(posedge clk) disable iff (rst)
    (outs_valid && !outs_ready) |=> $stable(outs)
  ) else $error("shift_reg_break_dv: outs changed while valid and stalled");

endmodule

`default_nettype wire

// ==== verilog/shift_reg_break_dv_dataless.sv ====
// Valid-only shift register; all slots stall together, so input ready depends on output ready
`default_nettype none

module shift_reg_break_dv_dataless #(
  parameter int NUM_SLOTS = 2
) (
  input  wire logic clk,
  input  wire logic rst,
  input  wire logic ins_valid,
  input  wire logic outs_ready,
  output logic      outs_valid,
  output logic      ins_ready
);

  // Slot 0 is the input end, slot NUM_SLOTS-1 the output end
  logic [NUM_SLOTS-1:0] valid_reg;
  logic                 reg_en;

  // Shared enable for every slot
  // Bubbles shift too, only a held token in the last slot stops the line
  assign reg_en = ~outs_valid | outs_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_reg <= '0;
    end else if (reg_en) begin
      for (int i = NUM_SLOTS - 1; i > 0; i--) begin
        valid_reg[i] <= valid_reg[i-1];
      end
      valid_reg[0] <= ins_valid;
    end
  end

  assign outs_valid = valid_reg[NUM_SLOTS-1];

  // Ready goes back upstream unchanged
  assign ins_ready = reg_en;

  // A stalled token must still be offered on the next cycle
  a_hold_valid: assert property (
    @(posedge clk) disable iff (rst)
    (outs_valid && !outs_ready) |=> outs_valid
  ) else $error("shift_reg_break_dv_dataless: outs_valid dropped while stalled");

endmodule

`default_nettype wire
